// File: source/pcie_queue_defines.svh
`ifndef PCIE_QUEUE_DEFINES_SVH
`define PCIE_QUEUE_DEFINES_SVH

// queue index width, one table entry per application
`define QQ_APP_IDX_WIDTH 2
`define QQ_TABLE_DEPTH   (1 << `QQ_APP_IDX_WIDTH)

// BAR byte address, page index starts at bit 12
`define QQ_ADDR_WIDTH    16

// one entry is four 32-bit fields: tail, head, kmem_lo, kmem_hi
`define QQ_FIELD_WIDTH   32
`define QQ_FIELDS        4

// BAR data word holds exactly one entry
`define QQ_WORD_WIDTH    128
`define QQ_BE_WIDTH      16

`endif

// File: source/pcie_queue_pkg.sv
`default_nettype none

`include "pcie_queue_defines.svh"

package pcie_queue_pkg;

    // one queue table entry, seen either as raw dwords or as named fields
    // tail sits in dword 0, so it is the last member of the struct
    typedef union packed {
        logic [`QQ_FIELDS-1:0][`QQ_FIELD_WIDTH-1:0] dwords;
        struct packed {
            logic [`QQ_FIELD_WIDTH-1:0] kmem_hi;
            logic [`QQ_FIELD_WIDTH-1:0] kmem_lo;
            logic [`QQ_FIELD_WIDTH-1:0] head;
            logic [`QQ_FIELD_WIDTH-1:0] tail;
        } fields;
    } qq_entry_t;

endpackage

`default_nettype wire

// File: source/qt_port_if.sv
`default_nettype none

`include "pcie_queue_defines.svh"

// one port of the queue table
interface qt_port_if;

    logic [`QQ_APP_IDX_WIDTH-1:0] addr;
    logic                         rd_en;
    // one bit per field, written at the edge that samples it
    logic [`QQ_FIELDS-1:0]        wr_mask;
    pcie_queue_pkg::qq_entry_t    wr_data;
    // valid on the second edge after the edge that samples rd_en
    pcie_queue_pkg::qq_entry_t    rd_data;

    modport memory (
        input  addr, rd_en, wr_mask, wr_data,
        output rd_data
    );

    modport user (
        output addr, rd_en, wr_mask, wr_data,
        input  rd_data
    );

endinterface

`default_nettype wire

// File: source/queue_table.sv
`default_nettype none

`include "pcie_queue_defines.svh"

module queue_table
    import pcie_queue_pkg::*;
(
    input  wire          pcie_clk,
    qt_port_if.memory    port_a,
    qt_port_if.memory    port_b
);

    localparam int DEPTH = `QQ_TABLE_DEPTH;

    qq_entry_t mem [DEPTH];

    // first read stage of each port
    qq_entry_t rd_a_q;
    qq_entry_t rd_b_q;

    always_ff @(posedge pcie_clk) begin
        // per-field write enables on both ports
        for (int f = 0; f < `QQ_FIELDS; f++) begin
            if (port_a.wr_mask[f]) begin
                mem[port_a.addr].dwords[f] <= port_a.wr_data.dwords[f];
            end
            if (port_b.wr_mask[f]) begin
                mem[port_b.addr].dwords[f] <= port_b.wr_data.dwords[f];
            end
        end

        // reads return the contents from before a same-edge write
        if (port_a.rd_en) begin
            rd_a_q <= mem[port_a.addr];
        end
        if (port_b.rd_en) begin
            rd_b_q <= mem[port_b.addr];
        end

        port_a.rd_data <= rd_a_q;
        port_b.rd_data <= rd_b_q;
    end

    // the controller and the host must never collide on one field
    a_no_field_collision: assert property (
        @(posedge pcie_clk)
        !((port_a.addr == port_b.addr) && (|(port_a.wr_mask & port_b.wr_mask)))
    ) else $error("both table ports write the same field of entry %0d", port_a.addr);

endmodule

`default_nettype wire

// File: source/host_reg_port.sv
`default_nettype none

`include "pcie_queue_defines.svh"

module host_reg_port
    import pcie_queue_pkg::*;
(
    input  wire                           pcie_clk,
    input  wire                           pcie_reset_n,

    input  wire  [`QQ_ADDR_WIDTH-1:0]     pcie_address,
    input  wire                           pcie_write,
    input  wire                           pcie_read,
    input  wire  [`QQ_WORD_WIDTH-1:0]     pcie_writedata,
    input  wire  [`QQ_BE_WIDTH-1:0]       pcie_byteenable,
    output logic [`QQ_WORD_WIDTH-1:0]     pcie_readdata,
    output logic                          pcie_readdatavalid,

    qt_port_if.user                       tbl,

    output logic                          upd_valid,
    output logic [`QQ_APP_IDX_WIDTH-1:0]  upd_queue,
    output qq_entry_t                     upd_entry,
    output logic [`QQ_FIELDS-1:0]         upd_mask
);

    localparam int PAGE_LSB        = 12;
    localparam int BYTES_PER_FIELD = `QQ_BE_WIDTH / `QQ_FIELDS;

    logic [`QQ_APP_IDX_WIDTH-1:0] page_idx;
    logic [`QQ_FIELDS-1:0]        field_mask;

    // read waiting for a cycle without a write
    logic                         rd_pend;
    logic [`QQ_APP_IDX_WIDTH-1:0] rd_queue;
    logic                         rd_issue;
    // follows the table read delay
    logic [1:0]                   rd_pipe;

    assign page_idx = pcie_address[PAGE_LSB +: `QQ_APP_IDX_WIDTH];

    // a field lands only when all of its byte enables are set
    always_comb begin
        for (int f = 0; f < `QQ_FIELDS; f++) begin
            field_mask[f] = &pcie_byteenable[f*BYTES_PER_FIELD +: BYTES_PER_FIELD];
        end
    end

    // writes win the port, reads go out in the first free cycle
    assign rd_issue = !pcie_write && (pcie_read || rd_pend);

    always_comb begin
        tbl.addr    = (rd_pend && !pcie_write) ? rd_queue : page_idx;
        tbl.rd_en   = rd_issue;
        tbl.wr_mask = pcie_write ? field_mask : '0;
        tbl.wr_data = pcie_writedata;
    end

    // every accepted write also goes to the active-queue controller
    assign upd_valid = pcie_write;
    assign upd_queue = page_idx;
    assign upd_entry = pcie_writedata;
    assign upd_mask  = field_mask;

    always_ff @(posedge pcie_clk) begin
        if (!pcie_reset_n) begin
            rd_pend            <= 1'b0;
            rd_pipe            <= '0;
            pcie_readdatavalid <= 1'b0;
        end else begin
            rd_pend            <= pcie_write && (rd_pend || pcie_read);
            rd_pipe            <= {rd_pipe[0], rd_issue};
            pcie_readdatavalid <= rd_pipe[1];
        end
    end

    always_ff @(posedge pcie_clk) begin
        if (pcie_read) begin
            rd_queue <= page_idx;
        end
        if (rd_pipe[1]) begin
            pcie_readdata <= tbl.rd_data;
        end
    end

    // the host keeps at most one read in flight
    a_one_read_outstanding: assert property (
        @(posedge pcie_clk) disable iff (!pcie_reset_n)
        pcie_read |-> !(rd_pend || (|rd_pipe))
    ) else $error("host read issued while a previous read is outstanding");

endmodule

`default_nettype wire

// File: source/active_queue_ctrl.sv
`default_nettype none

`include "pcie_queue_defines.svh"

module active_queue_ctrl
    import pcie_queue_pkg::*;
(
    input  wire                           pcie_clk,
    input  wire                           pcie_reset_n,

    qt_port_if.user                       tbl,

    input  wire                           upd_valid,
    input  wire  [`QQ_APP_IDX_WIDTH-1:0]  upd_queue,
    input  wire  qq_entry_t               upd_entry,
    input  wire  [`QQ_FIELDS-1:0]         upd_mask,

    input  wire                           dma_start,
    input  wire  [`QQ_APP_IDX_WIDTH-1:0]  dma_queue,
    input  wire                           dma_done,
    input  wire  [`QQ_FIELD_WIDTH-1:0]    new_tail,

    output logic                          queue_ready,
    output logic [`QQ_FIELD_WIDTH-1:0]    f2c_tail,
    output logic [`QQ_FIELD_WIDTH-1:0]    f2c_head,
    output logic [2*`QQ_FIELD_WIDTH-1:0]  f2c_kmem_addr
);

    typedef enum logic [2:0] {idle, wait_dma, delay_1, delay_2, switch} state_t;

    state_t                       state;
    logic [`QQ_APP_IDX_WIDTH-1:0] queue_id;
    logic                         queue_inv;
    logic [`QQ_APP_IDX_WIDTH-1:0] load_queue;
    qq_entry_t                    live;
    // host writes to the incoming queue that the table read may have missed
    qq_entry_t                    patch;
    logic [`QQ_FIELDS-1:0]        patch_mask;

    logic                         queue_hit;
    logic                         start_load;
    logic                         done_write;
    logic                         upd_live;
    logic                         upd_load;

    assign queue_hit  = !queue_inv && (queue_id == dma_queue);
    assign start_load = (state == idle) && dma_start && !queue_hit;
    assign done_write = (state == wait_dma) && dma_done;
    // on the switch edge the incoming queue already counts as active
    assign upd_live   = upd_valid && ((state == switch) ? (upd_queue == load_queue) :
                                      (!queue_inv && (upd_queue == queue_id)));
    assign upd_load   = upd_valid &&
                        (upd_queue == ((state == idle) ? dma_queue : load_queue));

    // port_a reads the entry on a switch and writes back the tail on dma_done
    always_comb begin
        tbl.addr       = start_load ? dma_queue : queue_id;
        tbl.rd_en      = start_load;
        tbl.wr_mask    = '0;
        tbl.wr_mask[0] = done_write;
        tbl.wr_data    = '0;
        tbl.wr_data.fields.tail = new_tail;
    end

    assign f2c_tail      = live.fields.tail;
    assign f2c_head      = live.fields.head;
    assign f2c_kmem_addr = {live.fields.kmem_hi, live.fields.kmem_lo};

    always_ff @(posedge pcie_clk) begin
        if (!pcie_reset_n) begin
            state       <= idle;
            queue_id    <= '0;
            queue_inv   <= 1'b1;
            load_queue  <= '0;
            patch_mask  <= '0;
            queue_ready <= 1'b0;
            live        <= '0;
        end else begin
            queue_ready <= 1'b0;

            case (state)
                idle: begin
                    if (dma_start && queue_hit) begin
                        queue_ready <= 1'b1;
                        state       <= wait_dma;
                    end else if (start_load) begin
                        load_queue <= dma_queue;
                        patch_mask <= '0;
                        state      <= delay_1;
                    end
                end
                wait_dma: begin
                    if (dma_done) begin
                        live.fields.tail <= new_tail;
                        state            <= idle;
                    end
                end
                delay_1: state <= delay_2;
                delay_2: state <= switch;
                switch: begin
                    for (int f = 0; f < `QQ_FIELDS; f++) begin
                        live.dwords[f] <= patch_mask[f] ? patch.dwords[f] :
                                                          tbl.rd_data.dwords[f];
                    end
                    queue_id    <= load_queue;
                    queue_inv   <= 1'b0;
                    queue_ready <= 1'b1;
                    state       <= wait_dma;
                end
                default: state <= idle;
            endcase

            // host writes to the active queue go straight to the live copy
            if (upd_live) begin
                for (int f = 0; f < `QQ_FIELDS; f++) begin
                    if (upd_mask[f]) begin
                        live.dwords[f] <= upd_entry.dwords[f];
                    end
                end
            end

            // a new load starts from an empty patch
            if (upd_load) begin
                patch_mask <= (start_load ? '0 : patch_mask) | upd_mask;
            end
        end
    end

    always_ff @(posedge pcie_clk) begin
        if (upd_load) begin
            for (int f = 0; f < `QQ_FIELDS; f++) begin
                if (upd_mask[f]) begin
                    patch.dwords[f] <= upd_entry.dwords[f];
                end
            end
        end
    end

    // dma_done only answers a queue_ready
    a_done_after_ready: assert property (
        @(posedge pcie_clk) disable iff (!pcie_reset_n)
        dma_done |-> (state == wait_dma)
    ) else $error("dma_done received outside wait_dma, state %s", state.name());

endmodule

`default_nettype wire

// File: source/pcie_queue_top.sv
`default_nettype none

`include "pcie_queue_defines.svh"

module pcie_queue_top
    import pcie_queue_pkg::*;
(
    input  wire                           pcie_clk,
    input  wire                           pcie_reset_n,

    // BAR port
    input  wire  [`QQ_ADDR_WIDTH-1:0]     pcie_address,
    input  wire                           pcie_write,
    input  wire                           pcie_read,
    input  wire  [`QQ_WORD_WIDTH-1:0]     pcie_writedata,
    input  wire  [`QQ_BE_WIDTH-1:0]       pcie_byteenable,
    output logic [`QQ_WORD_WIDTH-1:0]     pcie_readdata,
    output logic                          pcie_readdatavalid,

    // DMA engine
    input  wire                           dma_start,
    input  wire  [`QQ_APP_IDX_WIDTH-1:0]  dma_queue,
    input  wire                           dma_done,
    input  wire  [`QQ_FIELD_WIDTH-1:0]    new_tail,
    output logic                          queue_ready,
    output logic [`QQ_FIELD_WIDTH-1:0]    f2c_tail,
    output logic [`QQ_FIELD_WIDTH-1:0]    f2c_head,
    output logic [2*`QQ_FIELD_WIDTH-1:0]  f2c_kmem_addr
);

    // host writes forwarded to the controller
    logic                         upd_valid;
    logic [`QQ_APP_IDX_WIDTH-1:0] upd_queue;
    qq_entry_t                    upd_entry;
    logic [`QQ_FIELDS-1:0]        upd_mask;

    qt_port_if port_a ();
    qt_port_if port_b ();

    queue_table u_queue_table (
        .pcie_clk (pcie_clk),
        .port_a   (port_a),
        .port_b   (port_b)
    );

    host_reg_port u_host_reg_port (
        .pcie_clk           (pcie_clk),
        .pcie_reset_n       (pcie_reset_n),
        .pcie_address       (pcie_address),
        .pcie_write         (pcie_write),
        .pcie_read          (pcie_read),
        .pcie_writedata     (pcie_writedata),
        .pcie_byteenable    (pcie_byteenable),
        .pcie_readdata      (pcie_readdata),
        .pcie_readdatavalid (pcie_readdatavalid),
        .tbl                (port_b),
        .upd_valid          (upd_valid),
        .upd_queue          (upd_queue),
        .upd_entry          (upd_entry),
        .upd_mask           (upd_mask)
    );

    active_queue_ctrl u_active_queue_ctrl (
        .pcie_clk      (pcie_clk),
        .pcie_reset_n  (pcie_reset_n),
        .tbl           (port_a),
        .upd_valid     (upd_valid),
        .upd_queue     (upd_queue),
        .upd_entry     (upd_entry),
        .upd_mask      (upd_mask),
        .dma_start     (dma_start),
        .dma_queue     (dma_queue),
        .dma_done      (dma_done),
        .new_tail      (new_tail),
        .queue_ready   (queue_ready),
        .f2c_tail      (f2c_tail),
        .f2c_head      (f2c_head),
        .f2c_kmem_addr (f2c_kmem_addr)
    );

endmodule

`default_nettype wire

// File: dv/queue_checker.sv
`default_nettype none

`include "pcie_queue_defines.svh"

module queue_checker (
    input  wire                           pcie_clk,
    input  wire                           pcie_reset_n,
    input  wire  [`QQ_WORD_WIDTH-1:0]     pcie_readdata,
    input  wire                           pcie_readdatavalid,
    input  wire                           queue_ready,
    input  wire  [`QQ_FIELD_WIDTH-1:0]    f2c_tail,
    input  wire  [`QQ_FIELD_WIDTH-1:0]    f2c_head,
    input  wire  [2*`QQ_FIELD_WIDTH-1:0]  f2c_kmem_addr,
    // expectations from the stimulus side
    input  wire  [`QQ_WORD_WIDTH-1:0]     exp_read,
    input  wire  [`QQ_WORD_WIDTH-1:0]     exp_live,
    input  wire                           live_strobe,
    input  wire                           quiet,
    output int                            check_count,
    output int                            error_count
);
    timeunit 1ns;
    timeprecision 100ps;

    int checks = 0;
    int errors = 0;

    assign check_count = checks;
    assign error_count = errors;

    task automatic compare(input string name, input logic [`QQ_WORD_WIDTH-1:0] expected,
                           input logic [`QQ_WORD_WIDTH-1:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED at %0d ns: %s expected %0h actual %0h",
                     $time, name, expected, actual);
        end
    endtask

    // outputs are registered, so the rising edge sees last cycle's values
    always @(posedge pcie_clk) begin
        if (pcie_reset_n) begin
            if (quiet) begin
                compare("pcie_readdatavalid", '0, pcie_readdatavalid);
                compare("queue_ready", '0, queue_ready);
            end
            if (pcie_readdatavalid) begin
                compare("pcie_readdata", exp_read, pcie_readdata);
            end
            if (queue_ready || live_strobe) begin
                compare("f2c_tail", exp_live[31:0], f2c_tail);
                compare("f2c_head", exp_live[63:32], f2c_head);
                // kmem_hi sits above kmem_lo
                compare("f2c_kmem_addr", exp_live[127:64], f2c_kmem_addr);
            end
        end
    end

endmodule

`default_nettype wire

// File: dv/tb_pcie_queue.sv
`default_nettype none

`include "pcie_queue_defines.svh"

module tb_pcie_queue;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int WAIT_LIMIT = 50;
    localparam int BE_GROUP   = `QQ_BE_WIDTH / `QQ_FIELDS;

    logic                          pcie_clk = 1'b0;
    logic                          pcie_reset_n;
    logic [`QQ_ADDR_WIDTH-1:0]     pcie_address;
    logic                          pcie_write;
    logic                          pcie_read;
    logic [`QQ_WORD_WIDTH-1:0]     pcie_writedata;
    logic [`QQ_BE_WIDTH-1:0]       pcie_byteenable;
    logic [`QQ_WORD_WIDTH-1:0]     pcie_readdata;
    logic                          pcie_readdatavalid;
    logic                          dma_start;
    logic [`QQ_APP_IDX_WIDTH-1:0]  dma_queue;
    logic                          dma_done;
    logic [`QQ_FIELD_WIDTH-1:0]    new_tail;
    logic                          queue_ready;
    logic [`QQ_FIELD_WIDTH-1:0]    f2c_tail;
    logic [`QQ_FIELD_WIDTH-1:0]    f2c_head;
    logic [2*`QQ_FIELD_WIDTH-1:0]  f2c_kmem_addr;

    logic [`QQ_WORD_WIDTH-1:0]     exp_read;
    logic [`QQ_WORD_WIDTH-1:0]     exp_live;
    logic                          live_strobe;
    logic                          quiet;
    int                            check_count;
    int                            error_count;

    // reference copy of the table as host writes and dma_done leave it
    logic [`QQ_WORD_WIDTH-1:0]     model [`QQ_TABLE_DEPTH];
    int                            active_q;
    bit                            active_valid;
    logic [31:0]                   lcg_state = 32'hc9182a2e;
    int                            timeouts;
    int                            file_errors;

    always #10 pcie_clk = ~pcie_clk;

    pcie_queue_top dut (.*);

    queue_checker u_checker (.*);

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // a field changes only when its whole byte-enable group is set
    function automatic logic [`QQ_WORD_WIDTH-1:0] merge_fields(
        input logic [`QQ_WORD_WIDTH-1:0] old, input logic [`QQ_WORD_WIDTH-1:0] data,
        input logic [`QQ_BE_WIDTH-1:0] be);
        logic [`QQ_WORD_WIDTH-1:0] res;
        res = old;
        for (int f = 0; f < `QQ_FIELDS; f++) begin
            if (&be[f*BE_GROUP +: BE_GROUP]) begin
                res[f*`QQ_FIELD_WIDTH +: `QQ_FIELD_WIDTH] =
                    data[f*`QQ_FIELD_WIDTH +: `QQ_FIELD_WIDTH];
            end
        end
        return res;
    endfunction

    function automatic logic [`QQ_WORD_WIDTH-1:0] live_model();
        return active_valid ? model[active_q] : '0;
    endfunction

    task automatic check_live(input logic [`QQ_WORD_WIDTH-1:0] expected);
        exp_live    = expected;
        live_strobe = 1'b1;
        @(negedge pcie_clk);
        live_strobe = 1'b0;
    endtask

    task automatic host_write(input int q, input logic [`QQ_BE_WIDTH-1:0] be,
                              input logic [`QQ_WORD_WIDTH-1:0] data);
        pcie_address        = '0;
        pcie_address[12 +: `QQ_APP_IDX_WIDTH] = q[`QQ_APP_IDX_WIDTH-1:0];
        pcie_byteenable     = be;
        pcie_writedata      = data;
        pcie_write          = 1'b1;
        @(negedge pcie_clk);
        pcie_write          = 1'b0;
        model[q]            = merge_fields(model[q], data, be);
    endtask

    task automatic host_read(input int q, input logic [`QQ_WORD_WIDTH-1:0] expected);
        int n;
        exp_read     = expected;
        pcie_address = '0;
        pcie_address[12 +: `QQ_APP_IDX_WIDTH] = q[`QQ_APP_IDX_WIDTH-1:0];
        pcie_read    = 1'b1;
        @(negedge pcie_clk);
        pcie_read    = 1'b0;
        n = 0;
        while (!pcie_readdatavalid && n < WAIT_LIMIT) begin
            @(negedge pcie_clk);
            n++;
        end
        if (!pcie_readdatavalid) begin
            $display("timeout waiting for pcie_readdatavalid after a read of queue %0d", q);
            timeouts++;
        end
        // the checker takes the word at the next rising edge
        @(negedge pcie_clk);
    endtask

    task automatic start_queue(input int q, input logic [`QQ_WORD_WIDTH-1:0] expected);
        int n;
        exp_live  = expected;
        dma_queue = q[`QQ_APP_IDX_WIDTH-1:0];
        dma_start = 1'b1;
        @(negedge pcie_clk);
        dma_start = 1'b0;
        n = 0;
        while (!queue_ready && n < WAIT_LIMIT) begin
            @(negedge pcie_clk);
            n++;
        end
        if (!queue_ready) begin
            $display("timeout waiting for queue_ready after dma_start on queue %0d", q);
            timeouts++;
        end else begin
            active_q     = q;
            active_valid = 1'b1;
        end
        @(negedge pcie_clk);
    endtask

    task automatic finish_dma(input logic [31:0] tail, input bit from_file,
                              input logic [`QQ_WORD_WIDTH-1:0] file_exp);
        new_tail = tail;
        dma_done = 1'b1;
        @(negedge pcie_clk);
        dma_done = 1'b0;
        model[active_q][31:0] = tail;
        check_live(from_file ? file_exp : live_model());
    endtask

    task automatic run_pattern(input string line);
        string                     op;
        string                     ent_s;
        int                        q;
        int                        got;
        logic [31:0]               val;
        logic [`QQ_WORD_WIDTH-1:0] ent;
        bit                        from_file;
        got = $sscanf(line, "%s %d %h %s", op, q, val, ent_s);
        if (got != 4 || q < 0 || q >= `QQ_TABLE_DEPTH) begin
            $display("pattern line could not be parsed: %s", line);
            file_errors++;
            return;
        end
        from_file = (ent_s != "-");
        ent = '0;
        if (from_file) begin
            got = $sscanf(ent_s, "%h", ent);
        end
        case (op)
            "W": begin
                if (!from_file) begin
                    for (int f = 0; f < `QQ_FIELDS; f++) begin
                        ent[f*`QQ_FIELD_WIDTH +: `QQ_FIELD_WIDTH] = lcg_next();
                    end
                end
                host_write(q, val[`QQ_BE_WIDTH-1:0], ent);
                // live outputs follow only the active queue
                check_live(live_model());
            end
            "R": host_read(q, from_file ? ent : model[q]);
            "S": start_queue(q, from_file ? ent : model[q]);
            "D": finish_dma(val, from_file, ent);
            default: begin
                $display("unknown operation %s in pattern file", op);
                file_errors++;
            end
        endcase
    endtask

    initial begin
        int    fd;
        int    n;
        string line;
        pcie_reset_n    = 1'b0;
        pcie_address    = '0;
        pcie_write      = 1'b0;
        pcie_read       = 1'b0;
        pcie_writedata  = '0;
        pcie_byteenable = '0;
        dma_start       = 1'b0;
        dma_queue       = '0;
        dma_done        = 1'b0;
        new_tail        = '0;
        exp_read        = '0;
        exp_live        = '0;
        live_strobe     = 1'b0;
        quiet           = 1'b1;
        for (int i = 0; i < `QQ_TABLE_DEPTH; i++) begin
            model[i] = '0;
        end

        repeat (8) @(negedge pcie_clk);
        pcie_reset_n = 1'b1;
        // nothing may pulse and the live registers stay clear after reset
        repeat (4) @(negedge pcie_clk);
        check_live('0);
        quiet = 1'b0;

        fd = $fopen("dv/queue_patterns.txt", "r");
        if (fd == 0) begin
            $display("could not open the pattern file dv/queue_patterns.txt");
            file_errors++;
        end else begin
            while (timeouts == 0 && !$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 1 && line.getc(0) != "#") begin
                    run_pattern(line);
                end
            end
            $fclose(fd);
        end

        repeat (4) @(negedge pcie_clk);
        $display("checks: %0d, value errors: %0d, timeouts: %0d, pattern errors: %0d",
                 check_count, error_count, timeouts, file_errors);
        if (check_count > 0 && error_count == 0 && timeouts == 0 && file_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+source
source/pcie_queue_pkg.sv
source/qt_port_if.sv
source/queue_table.sv
source/host_reg_port.sv
source/active_queue_ctrl.sv
source/pcie_queue_top.sv
dv/queue_checker.sv
dv/tb_pcie_queue.sv

// File: dv/queue_patterns.txt
# op queue value entry, entry is {kmem_hi, kmem_lo, head, tail} in hex
# W: value = byte enables, entry = write data; R/S/D: entry = expected word
# D: value = new tail; an entry of - means random data or the model's value
W 1 ffff 0000000a000010000000001000000020
R 1 0 0000000a000010000000001000000020
W 2 ffff 000000bb200020000000003000000040
W 2 0f0f 11111111222222223333333344444444
W 2 7e3c 55555555555555555555555555555555
R 2 0 000000bb222222220000003044444444
W 0 ffff -
W 3 ffff -
R 0 0 -
S 1 0 0000000a000010000000001000000020
D 1 00000021 0000000a000010000000001000000021
S 1 0 0000000a000010000000001000000021
D 1 00000022 0000000a000010000000001000000022
R 1 0 0000000a000010000000001000000022
W 1 00f0 00000000000000000000007700000000
R 1 0 0000000a000010000000007700000022
W 2 ffff -
S 3 0 -
D 3 12345678 -
R 3 0 -
S 2 0 -
R 2 0 -
